/* hw/fetch_pkg.sv */
package fetch_pkg;

    // Instruction, address and register field width
    localparam int WORD_W = 32;
    // Major opcode field in bits 6:0
    localparam int OPCODE_W = 7;

    typedef logic [WORD_W-1:0] word_t;

    // Major opcodes of interest to the predictor
    typedef enum logic [OPCODE_W-1:0] {
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        // Stands for any opcode without a control transfer
        OTHER  = 7'b0000000
    } opcode_t;

    // Address of the first fetch after reset
    localparam word_t RESET_PC = 32'h0000_0100;

    // Watchdog limit for an unanswered bus cycle
    localparam int BUS_TIMEOUT_CYCLES = 16;
    // Counter runs 0 to limit minus one
    localparam int TIMER_W = $clog2(BUS_TIMEOUT_CYCLES);

    // Wishbone read master states
    typedef enum logic [1:0] {
        IDLE,
        // cyc and stb high, waiting on the slave
        REQ,
        // Returned word waits for the fetch stage
        HOLD,
        // Cycle made stale by a redirect, response is dropped
        DISCARD
    } fetch_state_t;

endpackage

/* hw/bus_timeout_timer.sv */
`timescale 1ns/1ps

module bus_timeout_timer (
    input  logic CLK,
    input  logic nRST,
    input  logic busy,
    output logic timeout
);
    import fetch_pkg::*;

    logic [TIMER_W-1:0] count;

    // Last allowed cycle of an outstanding bus cycle
    assign timeout = busy && (count == TIMER_W'(BUS_TIMEOUT_CYCLES - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (!busy || timeout) begin
            // Restart for the next bus cycle
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Master leaves the cycle on timeout, so it never repeats
    assert property (@(posedge CLK) disable iff (!nRST)
        timeout |=> !busy);

endmodule

/* hw/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
    input  fetch_pkg::word_t pred_instr,
    input  fetch_pkg::word_t pred_pc,
    output logic             predict_taken,
    output fetch_pkg::word_t target_addr
);
    import fetch_pkg::*;

    opcode_t opcode;
    word_t   imm_b;
    word_t   imm_j;

    assign opcode = opcode_t'(pred_instr[OPCODE_W-1:0]);

    // B-type immediate, bit 0 always zero
    assign imm_b = {{20{pred_instr[31]}}, pred_instr[7], pred_instr[30:25],
                    pred_instr[11:8], 1'b0};

    // J-type immediate
    assign imm_j = {{12{pred_instr[31]}}, pred_instr[19:12], pred_instr[20],
                    pred_instr[30:21], 1'b0};

    always_comb begin
        predict_taken = 1'b0;
        target_addr   = pred_pc + imm_b;
        case (opcode)
            JAL: begin
                // Unconditional, always taken
                predict_taken = 1'b1;
                target_addr   = pred_pc + imm_j;
            end
            BRANCH: begin
                // Backward taken, forward not taken
                predict_taken = pred_instr[31];
            end
            JALR, OTHER: begin
                // Register target unknown here
                predict_taken = 1'b0;
            end
            default: begin
                predict_taken = 1'b0;
            end
        endcase
    end

endmodule

/* hw/fetch_bus_fsm.sv */
`timescale 1ns/1ps

module fetch_bus_fsm (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             ireq,
    input  fetch_pkg::word_t pc,
    input  logic             pc_redirect,
    input  logic             accept,
    input  logic             timeout,
    input  fetch_pkg::word_t wb_dat_i,
    input  logic             wb_ack,
    input  logic             wb_err,
    output logic             busy,
    output logic             insn_ready,
    output fetch_pkg::word_t insn_data,
    output fetch_pkg::word_t insn_addr,
    output logic             bus_fault,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [3:0]       wb_sel,
    output fetch_pkg::word_t wb_adr
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t next_state;
    logic         bus_done;

    // Slave answered or watchdog fired
    assign bus_done = wb_ack || wb_err || timeout;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // PC is about to change on a redirect, wait a cycle
                if (ireq && !pc_redirect) begin
                    next_state = REQ;
                end
            end
            REQ: begin
                if (pc_redirect) begin
                    next_state = bus_done ? IDLE : DISCARD;
                end else if (bus_done) begin
                    next_state = HOLD;
                end
            end
            HOLD: begin
                // Stale word is simply dropped on redirect
                if (accept || pc_redirect) begin
                    next_state = IDLE;
                end
            end
            DISCARD: begin
                if (bus_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            wb_adr <= '0;
        end else begin
            state <= next_state;
            // Address latched once per cycle, stable until the end
            if (state == IDLE && next_state == REQ) begin
                wb_adr <= pc;
            end
        end
    end

    // One-word hold buffer
    always_ff @(posedge CLK) begin
        if (state == REQ && next_state == HOLD) begin
            insn_data <= wb_dat_i;
            insn_addr <= wb_adr;
            bus_fault <= wb_err || (timeout && !wb_ack);
        end
    end

    // Discarded cycles stay open until the slave or watchdog ends them
    assign busy       = (state == REQ) || (state == DISCARD);
    assign wb_cyc     = busy;
    assign wb_stb     = busy;
    assign wb_we      = 1'b0;
    assign wb_sel     = 4'hF;
    assign insn_ready = (state == HOLD);

    // New cycles only go out to word-aligned addresses
    assert property (@(posedge CLK) disable iff (!nRST)
        $rose(wb_stb) |-> wb_adr[1:0] == 2'b00);

    // Cycle stays open with a steady address until the slave or watchdog ends it
    assert property (@(posedge CLK) disable iff (!nRST)
        wb_stb && !wb_ack && !wb_err && !timeout |=> wb_stb && $stable(wb_adr));

    // Watchdog bounds every cycle
    assert property (@(posedge CLK) disable iff (!nRST)
        $rose(wb_stb) |-> ##[1:BUS_TIMEOUT_CYCLES] !wb_stb);

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             redirect_valid,
    input  fetch_pkg::word_t redirect_pc,
    input  logic             ex_stall,
    input  logic             ex_flush,
    input  logic             insn_ready,
    input  fetch_pkg::word_t insn_data,
    input  fetch_pkg::word_t insn_addr,
    input  logic             bus_fault,
    input  logic             predict_taken,
    input  fetch_pkg::word_t target_addr,
    output logic             ireq,
    output fetch_pkg::word_t pc,
    output logic             pc_redirect,
    output logic             accept,
    output fetch_pkg::word_t pred_instr,
    output fetch_pkg::word_t pred_pc,
    output logic             fex_valid,
    output fetch_pkg::word_t fex_instr,
    output fetch_pkg::word_t fex_pc,
    output fetch_pkg::word_t fex_pc4,
    output logic             fex_pred_taken,
    output fetch_pkg::word_t fex_pred_target,
    output logic             fex_mal_insn,
    output logic             fex_fault_insn,
    output fetch_pkg::word_t fex_fault_addr
);
    import fetch_pkg::*;

    word_t pc4;
    word_t npc;
    logic  mal_pend;
    logic  mal_done;
    logic  load_mal;
    logic  squash;

    assign pc4 = pc + 32'd4;

    // Misaligned PC halts fetching until the next redirect
    assign ireq        = (pc[1:0] == 2'b00);
    assign mal_pend    = !ireq && !mal_done;
    assign pc_redirect = redirect_valid;

    // Held word waits on stall or flush, dropped on redirect
    assign accept   = insn_ready && !ex_stall && !ex_flush && !redirect_valid;
    assign load_mal = mal_pend && !ex_stall && !ex_flush && !redirect_valid;

    // Fault merge, either kind squashes the word
    assign squash = bus_fault || load_mal;

    // Faulted word must not steer the predictor
    assign pred_instr = bus_fault ? '0 : insn_data;
    assign pred_pc    = pc;

    // Redirect over prediction over sequential
    always_comb begin
        if (redirect_valid) begin
            npc = redirect_pc;
        end else if (predict_taken) begin
            npc = target_addr;
        end else begin
            npc = pc4;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc       <= RESET_PC;
            mal_done <= 1'b0;
        end else begin
            if (redirect_valid || accept) begin
                pc <= npc;
            end
            // One misalignment entry per bad target
            if (redirect_valid) begin
                mal_done <= 1'b0;
            end else if (load_mal) begin
                mal_done <= 1'b1;
            end
        end
    end

    // Fetch to execute register, control part
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fex_valid      <= 1'b0;
            fex_mal_insn   <= 1'b0;
            fex_fault_insn <= 1'b0;
        end else if (!ex_stall) begin
            // Flush gives a bubble, otherwise take whatever is ready
            fex_valid      <= !ex_flush && (accept || load_mal);
            fex_mal_insn   <= load_mal;
            fex_fault_insn <= accept && bus_fault;
        end
    end

    // Payload part
    always_ff @(posedge CLK) begin
        if (accept || load_mal) begin
            fex_instr       <= squash ? '0 : insn_data;
            fex_pc          <= pc;
            fex_pc4         <= pc4;
            fex_pred_taken  <= accept && predict_taken;
            fex_pred_target <= target_addr;
            // Bad target itself for misalignment
            fex_fault_addr  <= load_mal ? pc : insn_addr;
        end
    end

    // Once its entry is out, a misaligned PC leaves only that entry or a bubble
    assert property (@(posedge CLK) disable iff (!nRST)
        (pc[1:0] != 2'b00) && !mal_pend |-> fex_mal_insn || !fex_valid);

    // Bus side releases the word right after the handshake
    assert property (@(posedge CLK) disable iff (!nRST)
        accept |=> !insn_ready);

endmodule

/* hw/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             redirect_valid,
    input  fetch_pkg::word_t redirect_pc,
    input  logic             ex_stall,
    input  logic             ex_flush,
    output logic             fex_valid,
    output fetch_pkg::word_t fex_instr,
    output fetch_pkg::word_t fex_pc,
    output fetch_pkg::word_t fex_pc4,
    output logic             fex_pred_taken,
    output fetch_pkg::word_t fex_pred_target,
    output logic             fex_mal_insn,
    output logic             fex_fault_insn,
    output fetch_pkg::word_t fex_fault_addr,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [3:0]       wb_sel,
    output fetch_pkg::word_t wb_adr,
    input  fetch_pkg::word_t wb_dat_i,
    input  logic             wb_ack,
    input  logic             wb_err
);
    import fetch_pkg::*;

    // Stage to bus master handshake
    logic  ireq;
    logic  pc_redirect;
    logic  accept;
    word_t pc;
    logic  insn_ready;
    logic  bus_fault;
    word_t insn_data;
    word_t insn_addr;

    // Watchdog
    logic  busy;
    logic  timeout;

    // Predictor lookup, combinational
    word_t pred_instr;
    word_t pred_pc;
    logic  predict_taken;
    word_t target_addr;

    fetch_stage fetch_stage_i (
        .CLK, .nRST, .redirect_valid, .redirect_pc, .ex_stall, .ex_flush,
        .insn_ready, .insn_data, .insn_addr, .bus_fault, .predict_taken, .target_addr,
        .ireq, .pc, .pc_redirect, .accept, .pred_instr, .pred_pc,
        .fex_valid, .fex_instr, .fex_pc, .fex_pc4, .fex_pred_taken, .fex_pred_target,
        .fex_mal_insn, .fex_fault_insn, .fex_fault_addr
    );

    fetch_bus_fsm fetch_bus_fsm_i (
        .CLK, .nRST, .ireq, .pc, .pc_redirect, .accept, .timeout,
        .wb_dat_i, .wb_ack, .wb_err,
        .busy, .insn_ready, .insn_data, .insn_addr, .bus_fault,
        .wb_cyc, .wb_stb, .wb_we, .wb_sel, .wb_adr
    );

    bus_timeout_timer bus_timeout_timer_i (
        .CLK, .nRST, .busy, .timeout
    );

    branch_predictor branch_predictor_i (
        .pred_instr, .pred_pc, .predict_taken, .target_addr
    );

endmodule

/* tests/fetch_frontend_tb.sv */
`timescale 1ns/1ps

module fetch_frontend_tb;
    import fetch_pkg::*;

    localparam int MAX_REC = 64;

    logic CLK, nRST, redirect_valid, ex_stall, ex_flush;
    word_t redirect_pc;
    logic fex_valid, fex_pred_taken, fex_mal_insn, fex_fault_insn;
    word_t fex_instr, fex_pc, fex_pc4, fex_pred_target, fex_fault_addr;
    logic wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
    logic [3:0] wb_sel;
    word_t wb_adr, wb_dat_i;

    // Slave memory and event lists from the data file
    word_t mem_addr [MAX_REC];
    word_t mem_word [MAX_REC];
    int    mem_wait [MAX_REC];
    logic  mem_err  [MAX_REC];
    byte   ev_kind  [MAX_REC];
    int    ev_idx   [MAX_REC];
    int    ev_delay [MAX_REC];
    word_t ev_val   [MAX_REC];
    int mem_count, ev_count, ev_ptr, ev_wait, end_count;

    int value_errors, other_errors, cycle_count, cycle_limit;
    int entry_count, stall_left, stall_starts, bus_cnt;
    logic run_done, timed_out, halted, stb_prev;
    logic stall_q = 1'b0;
    logic flush_q = 1'b0;
    word_t exp_pc, last_adr, snap_pc, snap_instr;

    fetch_frontend fetch_frontend_i (.*);

    always #2 CLK = ~CLK;

    // Register load happens only on edges without stall
    always @(posedge CLK) begin
        stall_q <= ex_stall;
        flush_q <= ex_flush && !ex_stall;
    end

    function automatic int find_record(word_t addr);
        for (int i = 0; i < mem_count; i++) begin
            if (mem_addr[i] == addr) return i;
        end
        return -1;
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            value_errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_sel(string name, logic [3:0] exp, logic [3:0] act);
        if (exp !== act) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Reference model of one register entry, then step the expected PC
    task automatic check_entry();
        string tag;
        int r;
        logic taken, fault, mal;
        word_t instr, target, imm;
        tag = $sformatf("entry %0d", entry_count);
        taken = 1'b0;
        fault = 1'b0;
        mal = 1'b0;
        instr = '0;
        target = exp_pc + 32'd4;
        if (halted) begin
            other_errors++;
            $display("Error: %s arrived while fetching should be halted", tag);
        end
        if (exp_pc[1:0] != 2'b00) begin
            mal = 1'b1;
        end else begin
            r = find_record(exp_pc);
            if (r < 0 || mem_err[r] || mem_wait[r] >= BUS_TIMEOUT_CYCLES) begin
                fault = 1'b1;
            end else begin
                instr = mem_word[r];
                if (instr[6:0] == JAL) begin
                    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                    taken = 1'b1;
                    target = exp_pc + imm;
                end else if (instr[6:0] == BRANCH && instr[31]) begin
                    // Negative offset, predicted taken
                    imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                    taken = 1'b1;
                    target = exp_pc + imm;
                end
            end
        end
        check_word({tag, " fex_pc"}, exp_pc, fex_pc);
        check_word({tag, " fex_pc4"}, exp_pc + 32'd4, fex_pc4);
        check_word({tag, " fex_instr"}, instr, fex_instr);
        check_flag({tag, " fex_pred_taken"}, taken, fex_pred_taken);
        check_flag({tag, " fex_fault_insn"}, fault, fex_fault_insn);
        check_flag({tag, " fex_mal_insn"}, mal, fex_mal_insn);
        if (taken) check_word({tag, " fex_pred_target"}, target, fex_pred_target);
        if (fault || mal) check_word({tag, " fex_fault_addr"}, exp_pc, fex_fault_addr);
        halted = mal;
        if (!mal) exp_pc = target;
        entry_count++;
    endtask

    task automatic load_tests();
        int fd, rc, a, b;
        string line;
        byte tag;
        word_t w, v;
        fd = $fopen("tests/fetch_tests.dat", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Error: cannot open tests/fetch_tests.dat");
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 1) begin
                tag = line[0];
                if (tag == "M") begin
                    rc = $sscanf(line.substr(1, line.len() - 1), "%h %h %d %d", w, v, a, b);
                    mem_addr[mem_count] = w;
                    mem_word[mem_count] = v;
                    mem_wait[mem_count] = a;
                    mem_err[mem_count] = (b != 0);
                    mem_count++;
                end else if (tag == "R" || tag == "S" || tag == "F") begin
                    rc = $sscanf(line.substr(1, line.len() - 1), "%d %d %h", a, b, v);
                    ev_kind[ev_count] = tag;
                    ev_idx[ev_count] = a;
                    ev_delay[ev_count] = b;
                    ev_val[ev_count] = v;
                    ev_count++;
                end else if (tag == "D") begin
                    rc = $sscanf(line.substr(1, line.len() - 1), "%d", end_count);
                end
            end
        end
        $fclose(fd);
    endtask

    // Slave answers on the falling edge, so the master samples a settled value
    always @(negedge CLK) begin
        int r;
        wb_ack = 1'b0;
        wb_err = 1'b0;
        if (nRST && wb_stb) begin
            r = find_record(wb_adr);
            wb_dat_i = wb_adr ^ 32'h5a5a_5a5a;
            if (r < 0) begin
                wb_err = (bus_cnt == 0);
            end else if (mem_wait[r] <= BUS_TIMEOUT_CYCLES && bus_cnt == mem_wait[r]) begin
                wb_ack = !mem_err[r];
                wb_err = mem_err[r];
                if (!mem_err[r]) wb_dat_i = mem_word[r];
            end
            bus_cnt++;
            last_adr = wb_adr;
        end else begin
            r = find_record(last_adr);
            if (bus_cnt > 0 && r >= 0 && mem_wait[r] >= BUS_TIMEOUT_CYCLES &&
                bus_cnt != BUS_TIMEOUT_CYCLES) begin
                other_errors++;
                $display("Error: hanging cycle at %h held stb %0d cycles", last_adr, bus_cnt);
            end
            bus_cnt = 0;
        end
    end

    // Monitor first, then the execute-side events for the next edge
    always @(negedge CLK) begin
        if (nRST && !run_done && !timed_out) begin
            cycle_count++;
            if (cycle_count > cycle_limit) timed_out = 1'b1;
            if (flush_q && fex_valid) begin
                other_errors++;
                $display("Error: fex_valid still high on the edge after a flush");
            end
            if (stall_q) begin
                check_flag("stall fex_valid", 1'b1, fex_valid);
                check_word("stall fex_pc", snap_pc, fex_pc);
                check_word("stall fex_instr", snap_instr, fex_instr);
            end else if (fex_valid) begin
                check_entry();
            end
            if (wb_stb) begin
                // Read-only master with all byte lanes
                check_flag("bus wb_cyc", 1'b1, wb_cyc);
                check_flag("bus wb_we", 1'b0, wb_we);
                check_sel("bus wb_sel", 4'hF, wb_sel);
            end else begin
                check_flag("idle wb_cyc", 1'b0, wb_cyc);
            end
            if (wb_stb && !stb_prev) begin
                // Each new cycle fetches the next expected PC
                check_word("bus start wb_adr", exp_pc, wb_adr);
                if (stall_q) stall_starts++;
                if (stall_starts > 1) begin
                    other_errors++;
                    $display("Error: new bus cycle started at %h under stall", wb_adr);
                end
                if (wb_adr[1:0] != 2'b00 || exp_pc[1:0] != 2'b00) begin
                    other_errors++;
                    $display("Error: bus cycle started for a misaligned target");
                end
            end
            stb_prev = wb_stb;
            if (entry_count >= end_count) run_done = 1'b1;

            redirect_valid = 1'b0;
            ex_flush = 1'b0;
            if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) ex_stall = 1'b0;
            end
            if (ev_ptr < ev_count && entry_count >= ev_idx[ev_ptr]) begin
                if (ev_wait > 0) begin
                    ev_wait--;
                end else begin
                    if (ev_kind[ev_ptr] == "R") begin
                        redirect_valid = 1'b1;
                        redirect_pc = ev_val[ev_ptr];
                        exp_pc = ev_val[ev_ptr];
                        halted = 1'b0;
                    end else if (ev_kind[ev_ptr] == "S") begin
                        ex_stall = 1'b1;
                        stall_left = ev_val[ev_ptr];
                        stall_starts = 0;
                        snap_pc = fex_pc;
                        snap_instr = fex_instr;
                    end else begin
                        ex_flush = 1'b1;
                    end
                    ev_ptr++;
                    ev_wait = (ev_ptr < ev_count) ? ev_delay[ev_ptr] : 0;
                end
            end
        end
    end

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        ex_stall = 1'b0;
        ex_flush = 1'b0;
        wb_dat_i = '0;
        wb_ack = 1'b0;
        wb_err = 1'b0;
        {mem_count, ev_count, ev_ptr, end_count, value_errors, other_errors} = '0;
        {cycle_count, entry_count, stall_left, stall_starts, bus_cnt} = '0;
        {run_done, timed_out, halted, stb_prev} = '0;
        exp_pc = RESET_PC;
        last_adr = '0;
        load_tests();
        ev_wait = (ev_count > 0) ? ev_delay[0] : 0;
        // Limit from record wait states, hanging slaves and event lengths
        cycle_limit = 32 + 4 * end_count;
        for (int i = 0; i < mem_count; i++) begin
            cycle_limit += (mem_wait[i] >= BUS_TIMEOUT_CYCLES) ?
                BUS_TIMEOUT_CYCLES + 4 : mem_wait[i] + 4;
        end
        for (int i = 0; i < ev_count; i++) begin
            cycle_limit += ev_delay[i] + 4 + ((ev_kind[i] == "S") ? int'(ev_val[i]) : 0);
        end
        if (other_errors > 0) run_done = 1'b1;
        repeat (2) @(negedge CLK);
        check_flag("reset wb_cyc", 1'b0, wb_cyc);
        check_flag("reset wb_stb", 1'b0, wb_stb);
        check_flag("reset fex_valid", 1'b0, fex_valid);
        nRST = 1'b1;
        wait (run_done || timed_out);
        if (timed_out) begin
            $display("Error: run stopped after %0d cycles with %0d of %0d entries seen",
                     cycle_limit, entry_count, end_count);
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* fetch_frontend.f */
hw/fetch_pkg.sv
hw/bus_timeout_timer.sv
hw/branch_predictor.sv
hw/fetch_bus_fsm.sv
hw/fetch_stage.sv
hw/fetch_frontend.sv
tests/fetch_frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_frontend_tb -f fetch_frontend.f \
    --Mdir obj_dir -o fetch_frontend_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/fetch_frontend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

/* tests/fetch_tests.dat */
# M address word wait_states error_flag, address and word in hex
# R/S/F fetch_index delay value (redirect target or stall cycles), D total entries
M 00000100 00000013 0 0
M 00000104 00100093 2 0
M 00000108 00208113 1 0
M 0000010C 00000463 3 0
M 00000110 0F00006F 0 0
M 00000200 00300193 4 0
M 00000204 FE0006E3 1 0
M 000001F0 00400213 0 0
M 000001F4 00008067 2 0
M 000001F8 00500293 5 0
M 00000300 00600313 0 0
M 00000304 00700393 1 0
M 00000308 00000013 1 1
M 00000310 00000013 255 0
M 00000314 00800413 0 0
M 00000318 00900493 0 0
M 00000400 00A00513 1 0
M 00000404 00B00593 0 0
R 9 2 00000300
S 10 0 8
F 15 2 0
R 16 0 00000322
R 17 3 00000400
D 19
